//--- Makefile
# Verilator build and run of the real-time channel multiplexer testbench

VERILATOR ?= verilator
TOP       ?= realtime_channel_mux_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= Test passed
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^[+-]' $(FLIST))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run check clean

all: check

build: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

run: $(SIM)
	$(SIM) > $(LOG) 2>&1 || true
	cat $(LOG)

# The log decides pass or fail
check: run
	@if grep -qx '$(PASS_TEXT)' $(LOG); then \
	  echo "Simulation passed"; \
	else \
	  echo "Simulation failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- flist.f
source/chan_mux_pkg.sv
source/mux_select_regs.sv
source/channel_crossbar.sv
source/realtime_channel_mux.sv
tb/realtime_channel_mux_checker.sv
tb/realtime_channel_mux_tb.sv

//--- source/chan_mux_pkg.sv
// Shared definitions for the real-time channel multiplexer
// Channel counts, sample and select widths, and the config port states
package chan_mux_pkg;

  localparam int input_channels = 16;
  localparam int output_channels = 8;
  localparam int sample_width = 16;

  // One select field picks one of the input channels
  localparam int select_bits = $clog2(input_channels);

  // Field k of the config word sits at bits k*select_bits upward
  localparam int select_word_width = output_channels * select_bits;

  typedef logic [sample_width-1:0] sample_t;
  typedef logic [select_bits-1:0] select_t;

  // Config port states
  typedef enum logic {
    cfg_idle,   // Ready, waiting for a select word
    cfg_commit  // Cycle after acceptance, ready held low
  } cfg_state_t;

endpackage

//--- source/channel_crossbar.sv
// Registered 16-to-8 sample crossbar
// Each output takes the sample and valid flag of its selected input one
// cycle later, with valid forced low in the cycle its source changes
`timescale 1ns/10ps
module channel_crossbar (
  input  logic data_clk,
  input  logic config_reset,
  input  chan_mux_pkg::sample_t [chan_mux_pkg::input_channels-1:0] in_sample,
  input  logic [chan_mux_pkg::input_channels-1:0] in_valid,
  input  logic [chan_mux_pkg::select_word_width-1:0] active_select,
  input  logic [chan_mux_pkg::output_channels-1:0] select_changed,
  output chan_mux_pkg::sample_t [chan_mux_pkg::output_channels-1:0] out_sample,
  output logic [chan_mux_pkg::output_channels-1:0] out_valid
);

  chan_mux_pkg::select_t [chan_mux_pkg::output_channels-1:0] source;
  chan_mux_pkg::sample_t [chan_mux_pkg::output_channels-1:0] routed_sample;
  logic [chan_mux_pkg::output_channels-1:0] routed_valid;

  // Split the select word into one field per output
  assign source = active_select;

  always_comb begin
    for (int k = 0; k < chan_mux_pkg::output_channels; k++) begin
      routed_sample[k] = in_sample[source[k]];
      // A sample straddling a routing change is never marked valid
      routed_valid[k] = in_valid[source[k]] & ~select_changed[k];
    end
  end

  always_ff @(posedge data_clk) begin
    if (config_reset) begin
      out_sample <= '0;
      out_valid <= '0;
    end else begin
      out_sample <= routed_sample;
      out_valid <= routed_valid;
    end
  end

endmodule

//--- source/mux_select_regs.sv
// Routing select registers for the channel multiplexer
// Takes select words on a valid/ready port, holds the active routing
// and raises a one-cycle mask of outputs whose source changed
`timescale 1ns/10ps
module mux_select_regs (
  input  logic data_clk,
  input  logic config_reset,
  input  logic [chan_mux_pkg::select_word_width-1:0] config_data,
  input  logic config_valid,
  output logic config_ready,
  output logic [chan_mux_pkg::select_word_width-1:0] active_select,
  output logic [chan_mux_pkg::output_channels-1:0] select_changed
);

  chan_mux_pkg::cfg_state_t state;
  chan_mux_pkg::cfg_state_t next_state;

  logic accept;
  logic [chan_mux_pkg::output_channels-1:0] field_diff;

  // Pull select field k out of a packed select word
  function automatic chan_mux_pkg::select_t field_of(
    input logic [chan_mux_pkg::select_word_width-1:0] word,
    input int k
  );
    return word[k*chan_mux_pkg::select_bits +: chan_mux_pkg::select_bits];
  endfunction

  assign config_ready = (state == chan_mux_pkg::cfg_idle);
  assign accept = config_valid && config_ready;

  // Compare the offered word with the held word one field at a time
  always_comb begin
    for (int k = 0; k < chan_mux_pkg::output_channels; k++) begin
      field_diff[k] = (field_of(config_data, k) != field_of(active_select, k));
    end
  end

  always_comb begin
    next_state = state;
    unique case (state)
      chan_mux_pkg::cfg_idle: begin
        if (accept) begin
          next_state = chan_mux_pkg::cfg_commit;
        end
      end
      chan_mux_pkg::cfg_commit: begin
        next_state = chan_mux_pkg::cfg_idle; // Ready returns after one cycle
      end
      default: begin
        next_state = chan_mux_pkg::cfg_idle;
      end
    endcase
  end

  always_ff @(posedge data_clk) begin
    if (config_reset) begin
      state <= chan_mux_pkg::cfg_idle;
      active_select <= '0; // Every output routes input 0
      select_changed <= '0;
    end else begin
      state <= next_state;
      if (accept) begin
        active_select <= config_data;
        select_changed <= field_diff;
      end else begin
        select_changed <= '0; // Change mask lasts only the commit cycle
      end
    end
  end

endmodule

//--- source/realtime_channel_mux.sv
// Real-time channel multiplexer top level
// Routes any of 16 sampled input channels to each of 8 outputs, with the
// routing loaded through a valid/ready select word port
`timescale 1ns/10ps
module realtime_channel_mux (
  input  logic data_clk,
  input  logic config_reset,
  input  chan_mux_pkg::sample_t [chan_mux_pkg::input_channels-1:0] in_sample,
  input  logic [chan_mux_pkg::input_channels-1:0] in_valid,
  output chan_mux_pkg::sample_t [chan_mux_pkg::output_channels-1:0] out_sample,
  output logic [chan_mux_pkg::output_channels-1:0] out_valid,
  input  logic [chan_mux_pkg::select_word_width-1:0] config_data,
  input  logic config_valid,
  output logic config_ready
);

  logic [chan_mux_pkg::select_word_width-1:0] active_select;
  logic [chan_mux_pkg::output_channels-1:0] select_changed; // Pulses for one cycle

  mux_select_regs select_regs_i (
    .data_clk(data_clk),
    .config_reset(config_reset),
    .config_data(config_data),
    .config_valid(config_valid),
    .config_ready(config_ready),
    .active_select(active_select),
    .select_changed(select_changed)
  );

  channel_crossbar crossbar_i (
    .data_clk(data_clk),
    .config_reset(config_reset),
    .in_sample(in_sample),
    .in_valid(in_valid),
    .active_select(active_select),
    .select_changed(select_changed),
    .out_sample(out_sample),
    .out_valid(out_valid)
  );

endmodule

//--- tb/realtime_channel_mux_checker.sv
// Bound assertions for the real-time channel multiplexer
// Tracks the accepted select word itself and checks routing, blanking,
// the config handshake and the reset state
`timescale 1ns/10ps
module realtime_channel_mux_checker (
  input logic data_clk,
  input logic config_reset,
  input chan_mux_pkg::sample_t [chan_mux_pkg::input_channels-1:0] in_sample,
  input logic [chan_mux_pkg::input_channels-1:0] in_valid,
  input chan_mux_pkg::sample_t [chan_mux_pkg::output_channels-1:0] out_sample,
  input logic [chan_mux_pkg::output_channels-1:0] out_valid,
  input logic [chan_mux_pkg::select_word_width-1:0] config_data,
  input logic config_valid,
  input logic config_ready
);

  chan_mux_pkg::select_t [chan_mux_pkg::output_channels-1:0] held_select;
  chan_mux_pkg::select_t [chan_mux_pkg::output_channels-1:0] offered;
  logic [chan_mux_pkg::output_channels-1:0] held_changed;
  logic [chan_mux_pkg::output_channels-1:0] field_diff;
  chan_mux_pkg::sample_t [chan_mux_pkg::output_channels-1:0] picked_sample;
  logic [chan_mux_pkg::output_channels-1:0] picked_valid;
  logic accept;
  int unsigned failures = 0;

  assign offered = config_data;
  assign accept = config_valid && config_ready;

  always_comb begin
    for (int k = 0; k < chan_mux_pkg::output_channels; k++) begin
      field_diff[k] = (offered[k] != held_select[k]);
      picked_sample[k] = in_sample[held_select[k]];
      picked_valid[k] = in_valid[held_select[k]];
    end
  end

  always_ff @(posedge data_clk) begin
    if (config_reset) begin
      held_select <= '0;
      held_changed <= '0;
    end else if (accept) begin
      held_select <= offered;
      held_changed <= field_diff;
    end else begin
      held_changed <= '0;
    end
  end

  // Changed outputs are masked on both sides of the valid comparison
  routing_check: assert property (@(posedge data_clk) disable iff (config_reset)
    !$past(config_reset) |-> (out_sample == $past(picked_sample)) &&
      ((out_valid | $past(held_changed)) == ($past(picked_valid) | $past(held_changed))))
    else begin
      $error("Output sample or valid differs from the selected input");
      failures++;
    end

  blanking_check: assert property (@(posedge data_clk) disable iff (config_reset)
    !$past(config_reset) |-> ((out_valid & $past(held_changed)) == '0))
    else begin
      $error("Valid seen on an output whose source just changed");
      failures++;
    end

  ready_drop_check: assert property (@(posedge data_clk) disable iff (config_reset)
    accept |=> !config_ready)
    else begin
      $error("config_ready stayed high after an accepted word");
      failures++;
    end

  ready_return_check: assert property (@(posedge data_clk) disable iff (config_reset)
    !config_ready |=> config_ready)
    else begin
      $error("config_ready stayed low for more than one cycle");
      failures++;
    end

  reset_check: assert property (@(posedge data_clk)
    config_reset |=> (out_valid == '0) && (out_sample == '0) && config_ready)
    else begin
      $error("Outputs or config_ready wrong after reset");
      failures++;
    end

endmodule

bind realtime_channel_mux realtime_channel_mux_checker checker_i (
  .data_clk(data_clk),
  .config_reset(config_reset),
  .in_sample(in_sample),
  .in_valid(in_valid),
  .out_sample(out_sample),
  .out_valid(out_valid),
  .config_data(config_data),
  .config_valid(config_valid),
  .config_ready(config_ready)
);

//--- tb/realtime_channel_mux_tb.sv
// Testbench for the real-time channel multiplexer
// Drives random samples and select words on the falling edge and compares
// every output cycle with a reference model of routing, blanking and handshake
`timescale 1ns/10ps
module realtime_channel_mux_tb;

  localparam int ready_timeout = 20; // Cycles to wait for config_ready
  localparam int word_width = chan_mux_pkg::select_word_width;
  localparam int valid_width = chan_mux_pkg::input_channels;
  localparam int snap_width = 1 + chan_mux_pkg::output_channels
                            + chan_mux_pkg::output_channels * chan_mux_pkg::sample_width;

  logic data_clk;
  logic config_reset;
  chan_mux_pkg::sample_t [chan_mux_pkg::input_channels-1:0] in_sample;
  logic [chan_mux_pkg::input_channels-1:0] in_valid;
  chan_mux_pkg::sample_t [chan_mux_pkg::output_channels-1:0] out_sample;
  logic [chan_mux_pkg::output_channels-1:0] out_valid;
  logic [word_width-1:0] config_data;
  logic config_valid;
  logic config_ready;

  // Reference model state as it stands just before the next rising edge
  logic [word_width-1:0] ref_select;
  logic [chan_mux_pkg::output_channels-1:0] ref_changed;
  logic ref_ready;

  integer seed;
  string test_name;
  int test_errors;
  int unsigned assert_base;
  logic value_mismatch;
  logic [snap_width-1:0] first_expected;
  logic [snap_width-1:0] first_actual;
  int pass_count;
  int fail_count;

  realtime_channel_mux UUT (
    .data_clk(data_clk),
    .config_reset(config_reset),
    .in_sample(in_sample),
    .in_valid(in_valid),
    .out_sample(out_sample),
    .out_valid(out_valid),
    .config_data(config_data),
    .config_valid(config_valid),
    .config_ready(config_ready)
  );

  initial begin
    data_clk = 1'b0;
    forever #50 data_clk = ~data_clk;
  end

  // Source input of output k, taken from the select word layout
  function automatic chan_mux_pkg::select_t source_of(
    input logic [word_width-1:0] word,
    input int k
  );
    return word[k*chan_mux_pkg::select_bits +: chan_mux_pkg::select_bits];
  endfunction

  task automatic start_test(input string name);
    test_name = name;
    test_errors = 0;
    assert_base = UUT.checker_i.failures;
    value_mismatch = 1'b0;
    first_expected = '0;
    first_actual = '0;
  endtask

  task automatic finish_test();
    int fired;
    fired = UUT.checker_i.failures - assert_base;
    if (test_errors == 0 && fired == 0) begin
      $display("%s pass", test_name);
      pass_count++;
    end else begin
      fail_count++;
      if (value_mismatch) begin
        $display("Fail %s expected %h actual %h (%0d errors)", test_name,
                 first_expected, first_actual, test_errors);
      end else if (fired != 0) begin
        $display("%s failed because bound assertions fired %0d times", test_name, fired);
      end else begin
        $display("%s did not finish because config_ready never came back", test_name);
      end
    end
  endtask

  // Keeps the first mismatch of a test for its report line
  task automatic check_value(input logic [snap_width-1:0] expected,
                             input logic [snap_width-1:0] actual);
    if (actual !== expected) begin
      if (!value_mismatch) begin
        first_expected = expected;
        first_actual = actual;
        value_mismatch = 1'b1;
      end
      test_errors++;
    end
  endtask

  task automatic drive_random(input logic all_valid);
    for (int i = 0; i < chan_mux_pkg::input_channels; i++) begin
      in_sample[i] = chan_mux_pkg::sample_t'($random(seed));
    end
    if (all_valid) begin
      in_valid = '1;
    end else begin
      in_valid = valid_width'($random(seed));
    end
  endtask

  // Runs one clock cycle from one falling edge to the next
  task automatic tick();
    chan_mux_pkg::sample_t [chan_mux_pkg::output_channels-1:0] exp_sample;
    logic [chan_mux_pkg::output_channels-1:0] exp_valid;
    logic [chan_mux_pkg::output_channels-1:0] diff;
    logic [word_width-1:0] offered;
    logic accepted;
    for (int k = 0; k < chan_mux_pkg::output_channels; k++) begin
      exp_sample[k] = in_sample[source_of(ref_select, k)];
      exp_valid[k] = in_valid[source_of(ref_select, k)] & ~ref_changed[k];
      diff[k] = (source_of(config_data, k) != source_of(ref_select, k));
    end
    accepted = config_valid & ref_ready;
    offered = config_data;
    @(posedge data_clk);
    @(negedge data_clk);
    if (accepted) begin
      ref_select = offered;
      ref_changed = diff;
    end else begin
      ref_changed = '0;
    end
    ref_ready = ~accepted; // Ready drops for the commit cycle only
    check_value({ref_ready, exp_valid, exp_sample}, {config_ready, out_valid, out_sample});
  endtask

  task automatic run_cycles(input int count, input logic all_valid);
    for (int n = 0; n < count; n++) begin
      drive_random(all_valid);
      tick();
    end
  endtask

  // Offers a word until it is taken and may leave config_valid high
  task automatic load_word(input logic [word_width-1:0] word, input logic hold_valid);
    int waited;
    logic taken;
    config_data = word;
    config_valid = 1'b1;
    taken = 1'b0;
    waited = 0;
    while (!taken && waited < ready_timeout) begin
      taken = config_ready;
      tick();
      waited++;
    end
    if (!hold_valid) begin
      config_valid = 1'b0;
    end
    if (!taken) begin
      $display("Timeout in %s: config_ready stayed low for %0d cycles", test_name,
               ready_timeout);
      config_valid = 1'b0;
      test_errors++;
    end
  endtask

  task automatic reset_dut();
    config_reset = 1'b1;
    for (int n = 0; n < 5; n++) begin
      @(posedge data_clk);
      @(negedge data_clk);
    end
    check_value({1'b1, {(snap_width-1){1'b0}}}, {config_ready, out_valid, out_sample});
    config_reset = 1'b0;
    ref_select = '0;
    ref_changed = '0;
    ref_ready = 1'b1;
  endtask

  initial begin
    logic [word_width-1:0] word;
    logic [word_width-1:0] second;
    chan_mux_pkg::select_t field;
    seed = 86;
    config_reset = 1'b1;
    in_sample = '0;
    in_valid = '0;
    config_data = '0;
    config_valid = 1'b0;
    ref_select = '0;
    ref_changed = '0;
    ref_ready = 1'b1;
    pass_count = 0;
    fail_count = 0;

    start_test("reset_state");
    reset_dut();
    run_cycles(10, 1'b0); // No word is loaded yet so all outputs follow input 0
    finish_test();

    start_test("identity_routing");
    for (int k = 0; k < chan_mux_pkg::output_channels; k++) begin
      word[k*chan_mux_pkg::select_bits +: chan_mux_pkg::select_bits] =
        chan_mux_pkg::select_t'(k);
    end
    drive_random(1'b1);
    load_word(word, 1'b0);
    run_cycles(20, 1'b1);
    finish_test();

    for (int round = 1; round <= 5; round++) begin
      start_test($sformatf("random_routing_round_%0d", round));
      word = word_width'($random(seed));
      word[7*chan_mux_pkg::select_bits +: chan_mux_pkg::select_bits] =
        word[chan_mux_pkg::select_bits-1:0]; // Outputs 0 and 7 share a source
      drive_random(1'b0);
      load_word(word, 1'b0);
      run_cycles(50, 1'b0);
      finish_test();
    end

    start_test("blanking");
    word = word_width'($random(seed));
    drive_random(1'b1);
    load_word(word, 1'b0);
    run_cycles(5, 1'b1);
    // Move outputs 1, 4 and 6 to another source and keep the rest
    second = word;
    for (int k = 0; k < chan_mux_pkg::output_channels; k++) begin
      if (k == 1 || k == 4 || k == 6) begin
        field = source_of(word, k) + chan_mux_pkg::select_t'(1);
        second[k*chan_mux_pkg::select_bits +: chan_mux_pkg::select_bits] = field;
      end
    end
    load_word(second, 1'b0);
    drive_random(1'b1);
    tick();
    check_value(snap_width'(8'hAD), snap_width'(out_valid));
    run_cycles(5, 1'b1);
    finish_test();

    start_test("config_backpressure");
    word = word_width'($random(seed));
    second = ~word;
    drive_random(1'b1);
    load_word(word, 1'b1);
    check_value(snap_width'(1'b0), snap_width'(config_ready));
    drive_random(1'b1);
    load_word(second, 1'b0); // Offered while ready is still low
    run_cycles(10, 1'b0);
    finish_test();

    if (UUT.checker_i.failures != 0) begin
      $display("Bound assertions fired %0d times", UUT.checker_i.failures);
    end
    $display("Summary: %0d tests passing, %0d failing, %0d assertion failures",
             pass_count, fail_count, UUT.checker_i.failures);
    if (fail_count == 0 && UUT.checker_i.failures == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule
